/* logic/bp_pkg.sv */
/*
  branch predictor package: table sizes, pc field positions,
  bht counter encoding and the btb, lookup and update structs
*/
package bp_pkg;

  localparam int num_entries = 64;                  // btb and bht depth
  localparam int index_w     = 6;                   // table index width
  localparam int tag_w       = 24;                  // btb tag width
  localparam int addr_w      = 32;                  // pc and target width

  localparam int idx_lsb     = 2;                   // index is pc[7:2], word aligned
  localparam int tag_lsb     = idx_lsb + index_w;   // tag is pc[31:8]

  localparam logic [index_w-1:0] last_index = index_w'(num_entries - 1); // end of clear sweep
  localparam logic [addr_w-1:0]  pc_step    = addr_w'(4);                // sequential fetch

  // 2-bit saturating counter, msb set means predict taken
  typedef enum logic [1:0] {
    strong_nt = 2'd0,
    weak_nt   = 2'd1,
    weak_t    = 2'd2,
    strong_t  = 2'd3
  } ctr_t;

  localparam ctr_t ctr_reset = weak_nt;             // value left behind by the sweep

  typedef struct packed {
    logic             valid;                        // entry holds a taken branch
    logic [tag_w-1:0] tag;                          // upper pc bits
  } btb_entry_t;

  typedef struct packed {
    logic [addr_w-1:0] pc;                          // pc of the resolved branch
    logic [addr_w-1:0] target;                      // actual branch target
    logic              taken;                       // branch outcome
    logic              mispredict;                  // fetch went the wrong way
  } resolve_t;

  typedef struct packed {
    logic              hit;                         // valid entry with matching tag
    logic [addr_w-1:0] target;                      // stored target
    ctr_t              ctr;                         // counter at the same index
  } lookup_t;

endpackage

/* logic/btb_table.sv */
/*
  direct-mapped branch target buffer, valid/tag array plus target array,
  combinational lookup and one clocked write or clear port
*/
`timescale 1ns/1ps

module btb_table (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [bp_pkg::index_w-1:0]        rd_index,   // from fetch pc
  input  logic [bp_pkg::tag_w-1:0]          rd_tag,     // from fetch pc
  input  logic                              we,         // write a taken branch
  input  logic                              clear,      // drop the entry at wr_index
  input  logic [bp_pkg::index_w-1:0]        wr_index,
  input  bp_pkg::btb_entry_t                wr_entry,
  input  logic [bp_pkg::addr_w-1:0]         wr_target,
  output bp_pkg::lookup_t                   rd
);

  logic                       valid_q  [bp_pkg::num_entries]; // per entry valid bit
  logic [bp_pkg::tag_w-1:0]   tag_q    [bp_pkg::num_entries]; // payload, no reset
  logic [bp_pkg::addr_w-1:0]  target_q [bp_pkg::num_entries]; // payload, no reset

  bp_pkg::btb_entry_t         rd_entry;                       // valid and tag at rd_index

  // valid bits are control state, cleared on reset and by the sweep
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < bp_pkg::num_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (clear) begin
      valid_q[wr_index] <= 1'b0;                    // sweep clears one index per cycle
    end else if (we) begin
      valid_q[wr_index] <= wr_entry.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      tag_q[wr_index]    <= wr_entry.tag;           // tag and target land together
      target_q[wr_index] <= wr_target;
    end
  end

  // lookup, same cycle as the fetch pc
  always_comb begin
    rd_entry.valid = valid_q[rd_index];
    rd_entry.tag   = tag_q[rd_index];
    rd.hit         = rd_entry.valid && (rd_entry.tag == rd_tag);
    rd.target      = target_q[rd_index];
    rd.ctr         = bp_pkg::ctr_reset;             // counter comes from the bht
  end

  // the control block never writes and sweeps in the same cycle
  a_no_we_with_clear: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(we && clear)
  );

endmodule

/* logic/bht_counters.sv */
/*
  branch history table, one 2-bit saturating counter per index,
  combinational read and clocked saturating update or clear
*/
`timescale 1ns/1ps

module bht_counters (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [bp_pkg::index_w-1:0]    rd_index,   // from fetch pc
  input  logic                          we,         // accepted resolve
  input  logic                          clear,      // sweep write of ctr_reset
  input  logic [bp_pkg::index_w-1:0]    wr_index,
  input  logic                          taken,      // direction to step toward
  output bp_pkg::ctr_t                  rd
);

  bp_pkg::ctr_t ctr_q [bp_pkg::num_entries];        // counter array
  bp_pkg::ctr_t cur_ctr;                            // counter being updated
  bp_pkg::ctr_t step_ctr;                           // its saturated next value

  // saturating step, holds at strong_t and strong_nt
  always_comb begin
    cur_ctr  = ctr_q[wr_index];
    step_ctr = cur_ctr;
    if (taken) begin
      if (cur_ctr != bp_pkg::strong_t) begin
        step_ctr = bp_pkg::ctr_t'(cur_ctr + 2'd1);  // toward taken
      end
    end else begin
      if (cur_ctr != bp_pkg::strong_nt) begin
        step_ctr = bp_pkg::ctr_t'(cur_ctr - 2'd1);  // toward not taken
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < bp_pkg::num_entries; i++) begin
        ctr_q[i] <= bp_pkg::ctr_reset;
      end
    end else if (clear) begin
      ctr_q[wr_index] <= bp_pkg::ctr_reset;        // sweep has priority
    end else if (we) begin
      ctr_q[wr_index] <= step_ctr;
    end
  end

  assign rd = ctr_q[rd_index];                      // lookup in the fetch cycle

endmodule

/* logic/bp_ctrl.sv */
/*
  predictor control: reset clear sweep, update handshake, table write
  enables, redirect over prediction priority and next pc selection
*/
`timescale 1ns/1ps

module bp_ctrl (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [bp_pkg::addr_w-1:0]         fetch_pc,
  input  logic                              is_branch,     // decode hint
  input  bp_pkg::resolve_t                  upd,           // resolved branch
  input  logic                              upd_valid,
  output logic                              upd_ready,
  input  bp_pkg::lookup_t                   btb_rd,        // btb answer for fetch_pc
  input  bp_pkg::ctr_t                      bht_rd,        // bht answer for fetch_pc
  output logic [bp_pkg::index_w-1:0]        wr_index,      // shared by both tables
  output logic                              btb_we,
  output bp_pkg::btb_entry_t                btb_wr,
  output logic [bp_pkg::addr_w-1:0]         btb_wr_target,
  output logic                              bht_we,
  output logic                              bht_clear,     // also clears btb valid bits
  output logic                              bht_taken,
  output logic [bp_pkg::addr_w-1:0]         next_pc,
  output logic                              hit
);

  logic [bp_pkg::index_w-1:0]  sweep_cnt;           // index being cleared
  logic                        busy;                // sweep in progress
  logic                        accept;              // handshake this cycle
  logic                        redirect;            // mispredict steers fetch
  logic                        pred_taken;          // counter msb
  logic                        pred_hit;            // btb hit and taken
  logic [bp_pkg::addr_w-1:0]   redirect_pc;         // corrected fetch address
  logic [bp_pkg::addr_w-1:0]   seq_pc;              // fetch_pc plus 4
  bp_pkg::lookup_t             pred;                // btb answer merged with counter

  // sweep, one index per edge, busy out of reset until index 63 is done
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sweep_cnt <= '0;
      busy      <= 1'b1;
    end else if (busy) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == bp_pkg::last_index) begin
        busy <= 1'b0;                               // ready from the 64th edge on
      end
    end
  end

  assign upd_ready = !busy;
  assign accept    = upd_valid && upd_ready;

  // table writes, sweep index or the resolved pc's index
  always_comb begin
    wr_index = busy ? sweep_cnt : upd.pc[bp_pkg::tag_lsb-1:bp_pkg::idx_lsb];
    bht_clear     = busy;
    bht_we        = accept;                         // every resolve trains the counter
    bht_taken     = upd.taken;
    btb_we        = accept && upd.taken;            // only taken branches allocate
    btb_wr.valid  = 1'b1;
    btb_wr.tag    = upd.pc[bp_pkg::addr_w-1:bp_pkg::tag_lsb];
    btb_wr_target = upd.target;
  end

  // prediction from the two tables
  always_comb begin
    pred       = btb_rd;
    pred.ctr   = bht_rd;                            // btb carries no counter
    pred_taken = (pred.ctr == bp_pkg::weak_t) || (pred.ctr == bp_pkg::strong_t);
    pred_hit   = is_branch && pred.hit && pred_taken && !busy; // cleared tables never hit
    seq_pc     = fetch_pc + bp_pkg::pc_step;
  end

  // redirect does not wait for ready
  always_comb begin
    redirect    = upd_valid && upd.mispredict;
    redirect_pc = upd.taken ? upd.target : (upd.pc + bp_pkg::pc_step);
  end

  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;                        // mispredict wins
      hit     = 1'b0;
    end else if (pred_hit) begin
      next_pc = pred.target;
      hit     = 1'b1;
    end else begin
      next_pc = seq_pc;
      hit     = 1'b0;
    end
  end

  // once the sweep is over, tables only change on a handshake
  a_no_idle_write: assert property (
    @(posedge clk) disable iff (!arst_n)
    (!busy && !(upd_valid && upd_ready)) |-> !(btb_we || bht_we || bht_clear)
  );

  a_no_hit_on_redirect: assert property (
    @(posedge clk) disable iff (!arst_n)
    (upd_valid && upd.mispredict) |-> !hit
  );

  // the sweep ends exactly 64 cycles after it starts
  a_sweep_length: assert property (
    @(posedge clk) disable iff (!arst_n)
    (busy && sweep_cnt == '0) |-> ##(bp_pkg::num_entries) !busy
  );

endmodule

/* logic/branch_predictor.sv */
/*
  branch predictor top: control block, btb and bht counter tables
*/
`timescale 1ns/1ps

module branch_predictor (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [bp_pkg::addr_w-1:0]     fetch_pc,
  input  logic                          is_branch,   // decode says branch
  input  bp_pkg::resolve_t              upd,         // from execute/mem
  input  logic                          upd_valid,
  output logic                          upd_ready,   // low during the clear sweep
  output logic [bp_pkg::addr_w-1:0]     next_pc,
  output logic                          hit
);

  logic [bp_pkg::index_w-1:0]  rd_index;            // fetch pc index
  logic [bp_pkg::tag_w-1:0]    rd_tag;              // fetch pc tag
  bp_pkg::lookup_t             btb_rd;
  bp_pkg::ctr_t                bht_rd;
  logic [bp_pkg::index_w-1:0]  wr_index;
  logic                        btb_we;
  bp_pkg::btb_entry_t          btb_wr;
  logic [bp_pkg::addr_w-1:0]   btb_wr_target;
  logic                        bht_we;
  logic                        sweep_clear;         // clears both tables
  logic                        bht_taken;

  assign rd_index = fetch_pc[bp_pkg::tag_lsb-1:bp_pkg::idx_lsb];
  assign rd_tag   = fetch_pc[bp_pkg::addr_w-1:bp_pkg::tag_lsb];

  bp_ctrl u_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .fetch_pc      (fetch_pc),
    .is_branch     (is_branch),
    .upd           (upd),
    .upd_valid     (upd_valid),
    .upd_ready     (upd_ready),
    .btb_rd        (btb_rd),
    .bht_rd        (bht_rd),
    .wr_index      (wr_index),
    .btb_we        (btb_we),
    .btb_wr        (btb_wr),
    .btb_wr_target (btb_wr_target),
    .bht_we        (bht_we),
    .bht_clear     (sweep_clear),
    .bht_taken     (bht_taken),
    .next_pc       (next_pc),
    .hit           (hit)
  );

  btb_table u_btb (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_index  (rd_index),
    .rd_tag    (rd_tag),
    .we        (btb_we),
    .clear     (sweep_clear),
    .wr_index  (wr_index),
    .wr_entry  (btb_wr),
    .wr_target (btb_wr_target),
    .rd        (btb_rd)
  );

  bht_counters u_bht (
    .clk      (clk),
    .arst_n   (arst_n),
    .rd_index (rd_index),
    .we       (bht_we),
    .clear    (sweep_clear),
    .wr_index (wr_index),
    .taken    (bht_taken),
    .rd       (bht_rd)
  );

endmodule

/* bench/tb_branch_predictor.sv */
/*
  branch predictor testbench: reset and clear sweep check, then
  file driven lookup and update steps with next_pc and hit checks
*/
`timescale 1ns/1ps

module tb_branch_predictor;

  localparam int half_period  = 20;                       // 40 ns clock
  localparam int reset_cycles = 8;
  localparam int ready_limit  = 200;                      // cycles allowed for upd_ready
  localparam int sweep_limit  = bp_pkg::num_entries + 16; // sweep must end well before this

  logic                       clk;
  logic                       arst_n;
  logic [bp_pkg::addr_w-1:0]  fetch_pc;
  logic                       is_branch;
  bp_pkg::resolve_t           upd;
  logic                       upd_valid;
  logic                       upd_ready;
  logic [bp_pkg::addr_w-1:0]  next_pc;
  logic                       hit;

  // fields of the current vector line
  logic [31:0] v_test;
  logic [31:0] v_op;                                      // 0 lookup, 1 update
  logic [31:0] v_pc;
  logic [31:0] v_branch;
  logic [31:0] v_upc;
  logic [31:0] v_utgt;
  logic [31:0] v_taken;
  logic [31:0] v_misp;
  logic [31:0] v_valid;
  logic [31:0] v_exp_pc;
  logic [31:0] v_exp_hit;

  int check_count;
  int err_count;
  int test_count;
  int cur_test;
  int test_check_base;                                    // counts when the test started
  int test_err_base;
  bit aborted;                                            // a wait ran out or file missing

  branch_predictor dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .fetch_pc  (fetch_pc),
    .is_branch (is_branch),
    .upd       (upd),
    .upd_valid (upd_valid),
    .upd_ready (upd_ready),
    .next_pc   (next_pc),
    .hit       (hit)
  );

  always #(half_period) clk = ~clk;

  task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("mismatch at %0d ns: %s, expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  // one summary line per finished test
  task automatic close_test;
    test_count++;
    $display("test %0d: %0d checks, %0d errors", cur_test,
             check_count - test_check_base, err_count - test_err_base);
    test_check_base = check_count;
    test_err_base   = err_count;
  endtask

  task automatic wait_ready(output bit ok);
    int cycles;
    cycles = 0;
    while (!upd_ready && cycles < ready_limit) begin
      @(negedge clk);                                     // upd held stable meanwhile
      cycles++;
    end
    ok = upd_ready;
  endtask

  // count rising edges from reset release until upd_ready, lookups must miss
  task automatic check_sweep(output bit ok, output int edges);
    logic [31:0] expect_pc;
    edges = 0;
    while (!upd_ready && edges < sweep_limit) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      if (edges == 8) begin                               // redirect mid sweep still steers fetch
        upd.pc         = 32'h0000_1010;
        upd.target     = 32'h0000_5000;
        upd.taken      = 1'b1;
        upd.mispredict = 1'b1;
        upd_valid      = 1'b1;
        expect_pc      = 32'h0000_5000;
      end else begin
        upd_valid = 1'b0;
        expect_pc = fetch_pc + 32'd4;
      end
      #(half_period - 1);                                 // just before the next rising edge
      compare_value({31'b0, hit}, 32'd0, $sformatf("hit during sweep, edge %0d", edges));
      compare_value(next_pc, expect_pc, $sformatf("next_pc during sweep, edge %0d", edges));
    end
    ok = upd_ready;
  endtask

  // drive one vector on the falling edge, sample before the rising edge
  task automatic apply_vector;
    bit ok;
    @(negedge clk);
    fetch_pc       = v_pc;
    is_branch      = v_branch[0];
    upd.pc         = v_upc;
    upd.target     = v_utgt;
    upd.taken      = v_taken[0];
    upd.mispredict = v_misp[0];
    upd_valid      = v_valid[0];
    ok             = 1'b1;
    if (v_op != 32'd0) begin
      wait_ready(ok);                                     // accepted on the coming rising edge
    end
    if (!ok) begin
      $display("timeout: upd_ready stayed low for %0d cycles in test %0d",
               ready_limit, v_test);
      aborted = 1'b1;
    end else begin
      #(half_period - 1);
      compare_value(next_pc, v_exp_pc, $sformatf("test %0d next_pc for pc %h", v_test, v_pc));
      compare_value({31'b0, hit}, v_exp_hit, $sformatf("test %0d hit for pc %h", v_test, v_pc));
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    edges;
    string line;
    bit    ok;
    clk             = 1'b0;
    arst_n          = 1'b1;
    fetch_pc        = 32'h0000_1010;                      // branch pc used by the sweep checks
    is_branch       = 1'b1;
    upd             = '0;
    upd_valid       = 1'b0;
    check_count     = 0;
    err_count       = 0;
    test_count      = 0;
    cur_test        = 1;                                  // reset and sweep belong to test 1
    test_check_base = 0;
    test_err_base   = 0;
    aborted         = 1'b0;
    fd              = 0;
    edges           = 0;

    #5 arst_n = 1'b0;                                     // clean falling edge on reset
    repeat (reset_cycles) begin
      @(negedge clk);
      compare_value({31'b0, upd_ready}, 32'd0, "upd_ready during reset");
      compare_value({31'b0, hit}, 32'd0, "hit during reset");
    end
    arst_n = 1'b1;                                        // released on a falling edge

    check_sweep(ok, edges);
    if (!ok) begin
      $display("timeout: upd_ready did not rise within %0d cycles of reset release",
               sweep_limit);
      aborted = 1'b1;
    end else begin
      compare_value(edges, 32'd64, "clear sweep length in cycles");
    end

    if (!aborted) begin
      fd = $fopen("bench/bp_tests.txt", "r");
      if (fd == 0) begin
        $display("could not open the vector file bench/bp_tests.txt");
        aborted = 1'b1;
      end
    end

    while (!aborted && fd != 0 && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", v_test, v_op, v_pc, v_branch,
                    v_upc, v_utgt, v_taken, v_misp, v_valid, v_exp_pc, v_exp_hit);
        if (n == 11) begin
          if (v_test != cur_test) begin                   // previous test is complete
            close_test();
            cur_test = v_test;
          end
          apply_vector();
        end else if (n > 0) begin                         // comments and blank lines give 0
          $display("malformed vector line: %s", line);
          err_count++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    close_test();
    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (aborted || err_count != 0) begin
      $display("TESTBENCH FAILED");
    end else begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  end

endmodule

/* bench/bp_tests.txt */
// columns: test op(0 lookup, 1 update) fetch_pc is_branch upd_pc upd_target
//          taken mispredict upd_valid expected_next_pc expected_hit, all hex

// test 1: cleared tables, every lookup falls through
1 0 00001000 1 00000000 00000000 0 0 0 00001004 0
1 0 00002040 1 00000000 00000000 0 0 0 00002044 0
1 0 0000fffc 0 00000000 00000000 0 0 0 00010000 0
1 0 00001010 1 00000000 00000000 0 0 0 00001014 0

// test 2: one taken update moves weak_nt to weak_t, next lookup hits
2 0 00001010 1 00000000 00000000 0 0 0 00001014 0
2 1 00001010 1 00001010 00003000 1 0 1 00001014 0
2 0 00001010 1 00000000 00000000 0 0 0 00003000 1
2 0 00001014 1 00000000 00000000 0 0 0 00001018 0

// test 3: saturate at strong_t, one not-taken keeps the hit, a second drops it
3 0 00001020 1 00000000 00000000 0 0 0 00001024 0
3 1 00001020 1 00001020 00004400 1 0 1 00001024 0
3 1 00001020 1 00001020 00004400 1 0 1 00004400 1
3 1 00001020 1 00001020 00004400 1 0 1 00004400 1
3 1 00001020 1 00001020 00004400 0 0 1 00004400 1
3 0 00001020 1 00000000 00000000 0 0 0 00004400 1
3 1 00001020 1 00001020 00004400 0 0 1 00004400 1
3 0 00001020 1 00000000 00000000 0 0 0 00001024 0

// test 4: same index with another tag misses, is_branch low never hits
4 0 00051010 1 00000000 00000000 0 0 0 00051014 0
4 0 00001010 0 00000000 00000000 0 0 0 00001014 0
4 0 00001010 1 00000000 00000000 0 0 0 00003000 1
4 0 00051020 1 00000000 00000000 0 0 0 00051024 0
4 1 00051010 1 00051010 00009000 1 0 1 00051014 0
4 0 00051010 1 00000000 00000000 0 0 0 00009000 1
4 0 00001010 1 00000000 00000000 0 0 0 00001014 0

// test 5: a mispredict overrides a hitting fetch pc
5 0 00051010 1 00000000 00000000 0 0 0 00009000 1
5 1 00051010 1 00002000 00006000 1 1 1 00006000 0
5 0 00002000 1 00000000 00000000 0 0 0 00006000 1
5 1 00051010 1 00002104 00007000 0 1 1 00002108 0
5 0 00002104 1 00000000 00000000 0 0 0 00002108 0
5 0 00051010 1 00000000 00000000 0 0 0 00009000 1
5 1 00000100 0 00002000 00006000 0 1 1 00002004 0
5 0 00002000 1 00000000 00000000 0 0 0 00002004 0

/* all.f */
logic/bp_pkg.sv
logic/btb_table.sv
logic/bht_counters.sv
logic/bp_ctrl.sv
logic/branch_predictor.sv
bench/tb_branch_predictor.sv

/* run.sh */
#!/bin/sh
# build the branch predictor testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_branch_predictor \
  -Mdir obj_dir -o sim_bp \
  -f all.f

# the simulator status is not trusted, the log decides
./obj_dir/sim_bp | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation failed, see sim.log"
  exit 1
fi
